// File: amul_macros.svh
`ifndef AMUL_MACROS_SVH
`define AMUL_MACROS_SVH

// operand and datapath widths
`define AMUL_OP_W 16
`define AMUL_MANT_W 8
`define AMUL_RES_W 32

// memory sizes
`define AMUL_IN_DEPTH 16
`define AMUL_PAIRS 8

// normalization stops after this many shifts
`define AMUL_MAX_SHIFT 7

`endif

// File: amul_ctrl_pkg.sv
package amul_ctrl_pkg;

    // fetch controller
    typedef enum logic [2:0] {
        FS_IDLE,
        FS_READ_A,
        FS_READ_B,
        FS_ISSUE,
        FS_WAIT,
        FS_DRAIN
    } fetch_state_t;

    // one operand normalizer
    typedef enum logic [1:0] {
        NS_IDLE,
        NS_SHIFT,
        NS_HOLD
    } norm_state_t;

endpackage

// File: amul_data_pkg.sv
`include "amul_macros.svh"

package amul_data_pkg;

    typedef logic [`AMUL_OP_W-1:0] operand_t;
    typedef logic [`AMUL_MANT_W-1:0] mantissa_t;

    // shift counts, single and summed
    typedef logic [$clog2(`AMUL_MAX_SHIFT+1)-1:0] shift_t;
    typedef logic [$clog2(2*`AMUL_MAX_SHIFT+1)-1:0] shift_sum_t;

    typedef logic [2*`AMUL_MANT_W-1:0] product_t;
    typedef logic [`AMUL_RES_W-1:0] result_t;

    // memory addressing
    typedef logic [$clog2(`AMUL_IN_DEPTH)-1:0] in_addr_t;
    typedef logic [$clog2(`AMUL_PAIRS)-1:0] pair_idx_t;

endpackage

// File: operand_fetch.sv
`timescale 1ns/1ps
`include "amul_macros.svh"

module operand_fetch import amul_ctrl_pkg::*, amul_data_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      in_wr_en,
    input  in_addr_t  in_wr_addr,
    input  operand_t  in_wr_data,
    input  logic      norm_busy,
    input  logic      done,
    output logic      busy,
    output logic      op_load,
    output operand_t  op_a,
    output operand_t  op_b,
    output pair_idx_t pair_idx
);

    operand_t     in_mem [`AMUL_IN_DEPTH];
    fetch_state_t state;
    pair_idx_t    pair_cnt;
    in_addr_t     rd_addr;
    logic         last_pair;

    // drops together with done
    assign busy = (state != FS_IDLE) && !done;
    assign op_load = (state == FS_ISSUE);
    assign pair_idx = pair_cnt;
    assign last_pair = (pair_cnt == pair_idx_t'(`AMUL_PAIRS - 1));
    // word 2k for A, 2k+1 for B
    assign rd_addr = {pair_cnt, (state == FS_READ_B)};

    //////////////////////////////////////////////////
    // input memory, host writes only when idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `AMUL_IN_DEPTH; i++) begin
                in_mem[i] <= '0;
            end
        end else if (in_wr_en && !busy) begin
            in_mem[in_wr_addr] <= in_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FS_READ_A) begin
            op_a <= in_mem[rd_addr];
        end
        if (state == FS_READ_B) begin
            op_b <= in_mem[rd_addr];
        end
    end

    //////////////////////////////////////////////////
    // pair sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FS_IDLE;
            pair_cnt <= '0;
        end else begin
            case (state)
                FS_IDLE: begin
                    if (start) begin
                        state <= FS_READ_A;
                        pair_cnt <= '0;
                    end
                end
                FS_READ_A: state <= FS_READ_B;
                FS_READ_B: state <= FS_WAIT;
                // normalizer must be free before issue
                FS_WAIT: begin
                    if (!norm_busy) begin
                        state <= FS_ISSUE;
                    end
                end
                FS_ISSUE: begin
                    if (last_pair) begin
                        state <= FS_DRAIN;
                    end else begin
                        pair_cnt <= pair_idx_t'(pair_cnt + 1'b1);
                        state <= FS_READ_A;
                    end
                end
                FS_DRAIN: begin
                    // busy is already low here, so a new start is taken
                    if (done) begin
                        state <= start ? FS_READ_A : FS_IDLE;
                        pair_cnt <= '0;
                    end
                end
                default: state <= FS_IDLE;
            endcase
        end
    end

endmodule

// File: operand_normalizer.sv
`timescale 1ns/1ps
`include "amul_macros.svh"

module operand_normalizer import amul_ctrl_pkg::*, amul_data_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load,
    input  operand_t  operand,
    output logic      ready,
    output mantissa_t mant,
    output shift_t    shift
);

    norm_state_t state;
    operand_t    sh_reg;
    shift_t      cnt;
    logic        finished;

    // leading one reached or shift limit hit
    assign finished = sh_reg[`AMUL_OP_W-1] || (cnt == shift_t'(`AMUL_MAX_SHIFT));
    assign ready = (state == NS_HOLD) || ((state == NS_SHIFT) && finished);
    assign mant = sh_reg[`AMUL_OP_W-1 -: `AMUL_MANT_W];
    assign shift = cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= NS_IDLE;
            cnt <= '0;
        end else if (load) begin
            state <= NS_SHIFT;
            cnt <= '0;
        end else if (state == NS_SHIFT) begin
            if (finished) begin
                state <= NS_HOLD;
            end else begin
                cnt <= shift_t'(cnt + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            sh_reg <= operand;
        end else if ((state == NS_SHIFT) && !finished) begin
            sh_reg <= {sh_reg[`AMUL_OP_W-2:0], 1'b0};
        end
    end

endmodule

// File: normalize_stage.sv
`timescale 1ns/1ps
`include "amul_macros.svh"

module normalize_stage import amul_data_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       op_load,
    input  operand_t   op_a,
    input  operand_t   op_b,
    input  pair_idx_t  pair_idx,
    output logic       norm_busy,
    output logic       norm_valid,
    output mantissa_t  mant_a,
    output mantissa_t  mant_b,
    output shift_sum_t shift_sum,
    output pair_idx_t  norm_pair
);

    logic   ready_a;
    logic   ready_b;
    shift_t shift_a;
    shift_t shift_b;

    operand_normalizer u_norm_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (op_load),
        .operand (op_a),
        .ready   (ready_a),
        .mant    (mant_a),
        .shift   (shift_a)
    );

    operand_normalizer u_norm_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (op_load),
        .operand (op_b),
        .ready   (ready_b),
        .mant    (mant_b),
        .shift   (shift_b)
    );

    // one pulse, when the slower side finishes
    assign norm_valid = norm_busy && ready_a && ready_b;
    assign shift_sum = shift_sum_t'(shift_a) + shift_sum_t'(shift_b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            norm_busy <= 1'b0;
        end else if (op_load) begin
            norm_busy <= 1'b1;
        end else if (norm_valid) begin
            norm_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op_load) begin
            norm_pair <= pair_idx;
        end
    end

endmodule

// File: mantissa_multiplier.sv
`timescale 1ns/1ps
`include "amul_macros.svh"

module mantissa_multiplier import amul_data_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       norm_valid,
    input  mantissa_t  mant_a,
    input  mantissa_t  mant_b,
    input  shift_sum_t shift_sum,
    input  pair_idx_t  norm_pair,
    output logic       prod_valid,
    output product_t   product,
    output shift_sum_t prod_shift,
    output pair_idx_t  prod_pair
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= norm_valid;
        end
    end

    // frees the normalizer for the next pair
    always_ff @(posedge clk) begin
        if (norm_valid) begin
            product <= product_t'(mant_a) * product_t'(mant_b);
            prod_shift <= shift_sum;
            prod_pair <= norm_pair;
        end
    end

endmodule

// File: denormalize_store.sv
`timescale 1ns/1ps
`include "amul_macros.svh"

module denormalize_store import amul_data_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       prod_valid,
    input  product_t   product,
    input  shift_sum_t prod_shift,
    input  pair_idx_t  prod_pair,
    input  pair_idx_t  res_rd_addr,
    output result_t    res_rd_data,
    output logic       done
);

    result_t res_mem [`AMUL_PAIRS];
    result_t widened;
    result_t shifted;
    logic    last_pair;

    //////////////////////////////////////////////////
    // undo both normalization shifts
    assign widened = {product, {(`AMUL_RES_W - $bits(product_t)){1'b0}}};
    assign shifted = widened >> prod_shift;
    assign last_pair = (prod_pair == pair_idx_t'(`AMUL_PAIRS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `AMUL_PAIRS; i++) begin
                res_mem[i] <= '0;
            end
        end else if (prod_valid) begin
            res_mem[prod_pair] <= shifted;
        end
    end

    // host read port
    assign res_rd_data = res_mem[res_rd_addr];

    //////////////////////////////////////////////////
    // completion, one cycle after the pair 7 write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= prod_valid && last_pair;
        end
    end

endmodule

// File: amul_top.sv
`timescale 1ns/1ps
`include "amul_macros.svh"

module amul_top import amul_data_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      in_wr_en,
    input  in_addr_t  in_wr_addr,
    input  operand_t  in_wr_data,
    input  pair_idx_t res_rd_addr,
    output logic      busy,
    output logic      done,
    output result_t   res_rd_data
);

    // fetch to normalize
    logic       op_load;
    operand_t   op_a;
    operand_t   op_b;
    pair_idx_t  pair_idx;
    logic       norm_busy;

    // normalize to multiply
    logic       norm_valid;
    mantissa_t  mant_a;
    mantissa_t  mant_b;
    shift_sum_t shift_sum;
    pair_idx_t  norm_pair;

    // multiply to store
    logic       prod_valid;
    product_t   product;
    shift_sum_t prod_shift;
    pair_idx_t  prod_pair;

    operand_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .in_wr_en   (in_wr_en),
        .in_wr_addr (in_wr_addr),
        .in_wr_data (in_wr_data),
        .norm_busy  (norm_busy),
        .done       (done),
        .busy       (busy),
        .op_load    (op_load),
        .op_a       (op_a),
        .op_b       (op_b),
        .pair_idx   (pair_idx)
    );

    normalize_stage u_norm (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_load    (op_load),
        .op_a       (op_a),
        .op_b       (op_b),
        .pair_idx   (pair_idx),
        .norm_busy  (norm_busy),
        .norm_valid (norm_valid),
        .mant_a     (mant_a),
        .mant_b     (mant_b),
        .shift_sum  (shift_sum),
        .norm_pair  (norm_pair)
    );

    mantissa_multiplier u_mult (
        .clk        (clk),
        .rst_n      (rst_n),
        .norm_valid (norm_valid),
        .mant_a     (mant_a),
        .mant_b     (mant_b),
        .shift_sum  (shift_sum),
        .norm_pair  (norm_pair),
        .prod_valid (prod_valid),
        .product    (product),
        .prod_shift (prod_shift),
        .prod_pair  (prod_pair)
    );

    denormalize_store u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .prod_valid  (prod_valid),
        .product     (product),
        .prod_shift  (prod_shift),
        .prod_pair   (prod_pair),
        .res_rd_addr (res_rd_addr),
        .res_rd_data (res_rd_data),
        .done        (done)
    );

endmodule

// File: amul_monitor.sv
`timescale 1ns/1ps
`include "amul_macros.svh"

module amul_monitor import amul_data_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_wr_en,
    input  in_addr_t  in_wr_addr,
    input  operand_t  in_wr_data,
    input  pair_idx_t res_rd_addr,
    input  result_t   res_rd_data,
    input  logic      rd_check,
    input  logic      run_end,
    input  int        run_num,
    output int        runs_passed,
    output int        runs_failed
);

    operand_t shadow [`AMUL_IN_DEPTH];
    int       run_errs;

    // leading-one search per operand up to the shift limit
    function automatic result_t ref_mult(input operand_t a, input operand_t b);
        operand_t                va;
        operand_t                vb;
        int                      sa;
        int                      sb;
        logic [2*`AMUL_MANT_W-1:0] prod;
        va = a;
        vb = b;
        sa = 0;
        sb = 0;
        while (!va[`AMUL_OP_W-1] && sa < `AMUL_MAX_SHIFT) begin
            va = va << 1;
            sa++;
        end
        while (!vb[`AMUL_OP_W-1] && sb < `AMUL_MAX_SHIFT) begin
            vb = vb << 1;
            sb++;
        end
        prod = va[`AMUL_OP_W-1 -: `AMUL_MANT_W] * vb[`AMUL_OP_W-1 -: `AMUL_MANT_W];
        return {prod, 16'h0000} >> (sa + sb);
    endfunction

    // copy of the input memory as the host loads it
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `AMUL_IN_DEPTH; i++) begin
                shadow[i] <= '0;
            end
        end else if (in_wr_en) begin
            shadow[in_wr_addr] <= in_wr_data;
        end
    end

    always @(posedge clk) begin
        result_t exp_val;
        if (!rst_n) begin
            run_errs = 0;
            runs_passed = 0;
            runs_failed = 0;
        end else begin
            if (rd_check) begin
                exp_val = ref_mult(shadow[{res_rd_addr, 1'b0}], shadow[{res_rd_addr, 1'b1}]);
                if (res_rd_data !== exp_val) begin
                    $display("[ERROR] res_rd_data addr %0d: expected %h, got %h",
                             res_rd_addr, exp_val, res_rd_data);
                    run_errs++;
                end
            end
            if (run_end) begin
                $display("run %0d: %0d of %0d results wrong", run_num, run_errs, `AMUL_PAIRS);
                if (run_errs == 0) begin
                    runs_passed++;
                end else begin
                    runs_failed++;
                end
                run_errs = 0;
            end
        end
    end

endmodule

// File: amul_chk.sv
`timescale 1ns/1ps

module amul_chk (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done,
    input logic op_load,
    input logic norm_busy,
    input logic norm_valid,
    input logic prod_valid
);

    int fail_cnt = 0;

    // issue only into a free normalizer
    a_load_free: assert property (@(posedge clk) disable iff (!rst_n)
        op_load |-> !norm_busy)
        else begin
            $error("op_load while norm_busy is high");
            fail_cnt++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            $error("done held longer than one cycle");
            fail_cnt++;
        end

    ////////////////////////////////////////////////
    // multiplier latency is exactly one cycle
    a_prod_after: assert property (@(posedge clk) disable iff (!rst_n)
        norm_valid |=> prod_valid)
        else begin
            $error("prod_valid missing after norm_valid");
            fail_cnt++;
        end

    a_prod_cause: assert property (@(posedge clk) disable iff (!rst_n)
        prod_valid |-> $past(norm_valid))
        else begin
            $error("prod_valid without norm_valid one cycle before");
            fail_cnt++;
        end

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !busy && !done)
        else begin
            $error("busy or done high right after reset");
            fail_cnt++;
        end

endmodule

bind amul_top amul_chk chk0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .busy       (busy),
    .done       (done),
    .op_load    (op_load),
    .norm_busy  (norm_busy),
    .norm_valid (norm_valid),
    .prod_valid (prod_valid)
);

// File: amul_tb.sv
`timescale 1ns/1ps
`include "amul_macros.svh"

module amul_tb import amul_data_pkg::*; ();

    localparam int NUM_FIXED = 3;
    localparam int NUM_RUNS = 6;
    localparam int CYCLE_LIMIT = NUM_RUNS * (16 + 8 * 12 + 16) * 2;

    logic      clk;
    logic      rst_n;
    logic      start;
    logic      in_wr_en;
    in_addr_t  in_wr_addr;
    operand_t  in_wr_data;
    pair_idx_t res_rd_addr;
    logic      busy;
    logic      done;
    result_t   res_rd_data;
    logic      rd_check;
    logic      run_end;
    int        run_num;
    int        runs_passed;
    int        runs_failed;
    int        tb_errs;
    int        cycle_cnt = 0;

    // rows hold bit 15 set, then zero and small, then mixed operands
    operand_t fixed_tab [NUM_FIXED][`AMUL_IN_DEPTH] = '{
        '{16'h8000, 16'hFFFF, 16'hC3A5, 16'h8001, 16'h9ABC, 16'hF00F, 16'hA5A5, 16'hD5D5,
          16'hFF00, 16'h80FF, 16'hE123, 16'hB00B, 16'h8888, 16'hC000, 16'hFFFF, 16'hFFFF},
        '{16'h0000, 16'h0000, 16'h0000, 16'h1234, 16'h00FF, 16'h00FF, 16'h0001, 16'h8000,
          16'h0080, 16'h0100, 16'h00C3, 16'hFFFF, 16'h007F, 16'h0003, 16'h0000, 16'h00AA},
        '{16'h1234, 16'h5678, 16'h0F0F, 16'hF0F0, 16'h0400, 16'h2000, 16'h7FFF, 16'h0001,
          16'h0042, 16'h3300, 16'h4000, 16'h4000, 16'h0200, 16'h00FF, 16'hBEEF, 16'h0ACE}
    };
    operand_t stim_tab [NUM_RUNS][`AMUL_IN_DEPTH];

    amul_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .in_wr_en    (in_wr_en),
        .in_wr_addr  (in_wr_addr),
        .in_wr_data  (in_wr_data),
        .res_rd_addr (res_rd_addr),
        .busy        (busy),
        .done        (done),
        .res_rd_data (res_rd_data)
    );

    amul_monitor mon0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_wr_en    (in_wr_en),
        .in_wr_addr  (in_wr_addr),
        .in_wr_data  (in_wr_data),
        .res_rd_addr (res_rd_addr),
        .res_rd_data (res_rd_data),
        .rd_check    (rd_check),
        .run_end     (run_end),
        .run_num     (run_num),
        .runs_passed (runs_passed),
        .runs_failed (runs_failed)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the runs did not finish", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // host side tasks
    task automatic load_run(input int r);
        for (int i = 0; i < `AMUL_IN_DEPTH; i++) begin
            @(posedge clk);
            #1;
            in_wr_en = 1'b1;
            in_wr_addr = in_addr_t'(i);
            in_wr_data = stim_tab[r][i];
        end
        @(posedge clk);
        #1;
        in_wr_en = 1'b0;
    endtask

    task automatic start_run();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (!busy) begin
            $display("busy did not rise the cycle after start");
            tb_errs++;
        end
        // second start lands while busy
        repeat (2) @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_done();
        while (!done) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
        if (busy) begin
            $display("busy high again after done, the start during the run was not ignored");
            tb_errs++;
        end
    endtask

    task automatic read_results();
        for (int k = 0; k < `AMUL_PAIRS; k++) begin
            @(posedge clk);
            #1;
            res_rd_addr = pair_idx_t'(k);
            rd_check = 1'b1;
        end
        @(posedge clk);
        #1;
        rd_check = 1'b0;
        run_end = 1'b1;
        @(posedge clk);
        #1;
        run_end = 1'b0;
    endtask

    //////////////////////////////////////////////////
    initial begin
        logic [31:0] rnd;
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        in_wr_en = 1'b0;
        in_wr_addr = '0;
        in_wr_data = '0;
        res_rd_addr = '0;
        rd_check = 1'b0;
        run_end = 1'b0;
        run_num = 0;
        tb_errs = 0;
        void'($urandom(62));
        for (int r = 0; r < NUM_RUNS; r++) begin
            for (int i = 0; i < `AMUL_IN_DEPTH; i++) begin
                rnd = $urandom;
                // random leading zeros give uneven normalize lengths
                if (r < NUM_FIXED) begin
                    stim_tab[r][i] = fixed_tab[r][i];
                end else begin
                    stim_tab[r][i] = operand_t'(rnd) >> ($urandom % 12);
                end
            end
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_num = r;
            load_run(r);
            start_run();
            wait_done();
            read_results();
        end
        $display("runs passed %0d, runs failed %0d, other errors %0d, assertion failures %0d",
                 runs_passed, runs_failed, tb_errs, dut0.chk0.fail_cnt);
        if (runs_failed == 0 && tb_errs == 0 && dut0.chk0.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
amul_ctrl_pkg.sv
amul_data_pkg.sv
operand_fetch.sv
operand_normalizer.sv
normalize_stage.sv
mantissa_multiplier.sv
denormalize_store.sv
amul_top.sv
amul_monitor.sv
amul_chk.sv
amul_tb.sv

// File: Bender.yml
package:
  name: amul

sources:
  - include_dirs:
      - .
    files:
      - amul_ctrl_pkg.sv
      - amul_data_pkg.sv
      - operand_fetch.sv
      - operand_normalizer.sv
      - normalize_stage.sv
      - mantissa_multiplier.sv
      - denormalize_store.sv
      - amul_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - amul_monitor.sv
      - amul_chk.sv
      - amul_tb.sv
